/* logic/mmu_pkg.sv */
package mmu_pkg;

    // CSR numbers
    localparam int CSR_NUM_W = 14;                          // CSR number width
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD = 14'h000;    // Current mode info
    localparam logic [CSR_NUM_W-1:0] CSR_ASID = 14'h018;    // Address space id
    localparam logic [CSR_NUM_W-1:0] CSR_DMW0 = 14'h180;    // Direct map window 0
    localparam logic [CSR_NUM_W-1:0] CSR_DMW1 = 14'h181;    // Direct map window 1

    localparam logic [31:0] CRMD_RESET = 32'h0000_0008;     // DA=1, PG=0, PLV=0

    // Field positions inside the CSR words
    localparam int CRMD_PLV_HI  = 1;
    localparam int CRMD_PLV_LO  = 0;
    localparam int CRMD_DA      = 3;                        // Direct address enable
    localparam int CRMD_PG      = 4;                        // Paging enable
    localparam int ASID_ASID_HI = 9;
    localparam int ASID_ASID_LO = 0;
    localparam int DMW_PLV0     = 0;                        // Window usable at PLV0
    localparam int DMW_PLV3     = 3;                        // Window usable at PLV3
    localparam int DMW_PSEG_HI  = 27;
    localparam int DMW_PSEG_LO  = 25;
    localparam int DMW_VSEG_HI  = 31;
    localparam int DMW_VSEG_LO  = 29;

    // TLB geometry
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;
    localparam int PPN_W       = 20;
    localparam int VPPN_W      = 19;                        // va[31:13]
    localparam int ASID_W      = 10;
    localparam logic [5:0] PS_4K = 6'd12;                   // 4 KB page
    localparam logic [5:0] PS_4M = 6'd22;                   // 4 MB page

    // Exception flag vector, MSB first
    localparam int EXC_W    = 6;
    localparam int EXC_PIL  = 5;                            // Load page invalid
    localparam int EXC_PIS  = 4;                            // Store page invalid
    localparam int EXC_PIF  = 3;                            // Fetch page invalid
    localparam int EXC_PME  = 2;                            // Page modified
    localparam int EXC_PPI  = 1;                            // Privilege violation
    localparam int EXC_TLBR = 0;                            // TLB refill

    // Request kind
    localparam logic [1:0] FLAG_INST = 2'b10;               // Instruction fetch
    localparam logic [1:0] FLAG_DATA = 2'b01;               // Load or store

    // CSR write word, decoded by CSR number
    typedef union packed {
        struct packed {
            logic [26:0] rsvd_hi;
            logic        pg;
            logic        da;
            logic        rsvd_lo;                           // IE slot, not kept
            logic [1:0]  plv;
        } crmd;
        struct packed {
            logic [21:0] rsvd;
            logic [9:0]  asid;
        } asid;
        struct packed {
            logic [2:0]  vseg;
            logic        rsvd_hi;
            logic [2:0]  pseg;
            logic [20:0] rsvd_mid;                          // MAT and PLV1/2 not kept
            logic        plv3;
            logic [1:0]  rsvd_lo;
            logic        plv0;
        } dmw;
    } csr_word_u;

endpackage

/* logic/mmu_csr_file.sv */
`timescale 1ns/10ps

module mmu_csr_file (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             csr_we,
    input  logic [mmu_pkg::CSR_NUM_W-1:0]    csr_num,
    input  mmu_pkg::csr_word_u               csr_wdata,
    output logic                             crmd_da,
    output logic                             crmd_pg,
    output logic [1:0]                       crmd_plv,
    output logic [mmu_pkg::ASID_W-1:0]       asid,
    output logic [31:0]                      dmw0,
    output logic [31:0]                      dmw1
);
    import mmu_pkg::*;

    logic [31:0] crmd_q;                                    // Mode word
    logic [31:0] asid_q;                                    // ASID word
    logic [31:0] dmw0_q;
    logic [31:0] dmw1_q;

    logic [31:0] crmd_wr;                                   // Masked write words
    logic [31:0] asid_wr;
    logic [31:0] dmw_wr;

    // Keep only the writable fields of each view, rest reads zero
    always_comb begin
        crmd_wr = '0;
        crmd_wr[CRMD_PLV_HI:CRMD_PLV_LO] = csr_wdata.crmd.plv;
        crmd_wr[CRMD_DA] = csr_wdata.crmd.da;
        crmd_wr[CRMD_PG] = csr_wdata.crmd.pg;

        asid_wr = '0;
        asid_wr[ASID_ASID_HI:ASID_ASID_LO] = csr_wdata.asid.asid;

        dmw_wr = '0;
        dmw_wr[DMW_PLV0] = csr_wdata.dmw.plv0;
        dmw_wr[DMW_PLV3] = csr_wdata.dmw.plv3;
        dmw_wr[DMW_PSEG_HI:DMW_PSEG_LO] = csr_wdata.dmw.pseg;
        dmw_wr[DMW_VSEG_HI:DMW_VSEG_LO] = csr_wdata.dmw.vseg;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_q <= CRMD_RESET;                           // Boot in direct mode
            asid_q <= '0;
            dmw0_q <= '0;
            dmw1_q <= '0;
        end else if (csr_we) begin
            case (csr_num)
                CSR_CRMD: crmd_q <= crmd_wr;
                CSR_ASID: asid_q <= asid_wr;
                CSR_DMW0: dmw0_q <= dmw_wr;
                CSR_DMW1: dmw1_q <= dmw_wr;
                default: ;                                  // Unknown number ignored
            endcase
        end
    end

    // Decoded levels for the translator
    assign crmd_da  = crmd_q[CRMD_DA];
    assign crmd_pg  = crmd_q[CRMD_PG];
    assign crmd_plv = crmd_q[CRMD_PLV_HI:CRMD_PLV_LO];
    assign asid     = asid_q[ASID_ASID_HI:ASID_ASID_LO];
    assign dmw0     = dmw0_q;
    assign dmw1     = dmw1_q;

endmodule

/* logic/mmu_tlb.sv */
`timescale 1ns/10ps

module mmu_tlb (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             tlb_we,
    input  logic [mmu_pkg::TLB_IDX_W-1:0]    tlb_widx,
    input  logic                             tlb_e,
    input  logic [mmu_pkg::VPPN_W-1:0]       tlb_vppn,
    input  logic [5:0]                       tlb_ps,
    input  logic                             tlb_g,
    input  logic [mmu_pkg::ASID_W-1:0]       tlb_asid,
    input  logic [mmu_pkg::PPN_W-1:0]        tlb_ppn,
    input  logic [1:0]                       tlb_plv,
    input  logic [1:0]                       tlb_mat,
    input  logic                             tlb_d,
    input  logic                             tlb_v,
    input  logic [mmu_pkg::VPPN_W-1:0]       s_vppn,
    input  logic [mmu_pkg::ASID_W-1:0]       s_asid,
    output logic                             s_found,
    output logic [mmu_pkg::TLB_IDX_W-1:0]    s_index,
    output logic [mmu_pkg::PPN_W-1:0]        s_ppn,
    output logic [5:0]                       s_ps,
    output logic [1:0]                       s_plv,
    output logic [1:0]                       s_mat,
    output logic                             s_d,
    output logic                             s_v
);
    import mmu_pkg::*;

    logic [TLB_ENTRIES-1:0] e_q;                            // Entry exists
    logic [VPPN_W-1:0]      vppn_q [TLB_ENTRIES];
    logic [5:0]             ps_q   [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] g_q;                            // Global, ignores ASID
    logic [ASID_W-1:0]      asid_q [TLB_ENTRIES];
    logic [PPN_W-1:0]       ppn_q  [TLB_ENTRIES];
    logic [1:0]             plv_q  [TLB_ENTRIES];
    logic [1:0]             mat_q  [TLB_ENTRIES];           // Kept, not acted on
    logic [TLB_ENTRIES-1:0] d_q;
    logic [TLB_ENTRIES-1:0] v_q;

    logic [TLB_ENTRIES-1:0] hit;                            // Per entry match

    // Only the exist bits are cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            e_q <= '0;
        end else if (tlb_we) begin
            e_q[tlb_widx] <= tlb_e;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            vppn_q[tlb_widx] <= tlb_vppn;
            ps_q[tlb_widx]   <= tlb_ps;
            g_q[tlb_widx]    <= tlb_g;
            asid_q[tlb_widx] <= tlb_asid;
            ppn_q[tlb_widx]  <= tlb_ppn;
            plv_q[tlb_widx]  <= tlb_plv;
            mat_q[tlb_widx]  <= tlb_mat;
            d_q[tlb_widx]    <= tlb_d;
            v_q[tlb_widx]    <= tlb_v;
        end
    end

    // Parallel compare, 4 MB pages use the top 9 vppn bits
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit[i] = e_q[i]
                && (g_q[i] || (asid_q[i] == s_asid))
                && ((ps_q[i] == PS_4M)
                    ? (vppn_q[i][VPPN_W-1:10] == s_vppn[VPPN_W-1:10])
                    : (vppn_q[i] == s_vppn));
        end
    end

    // Scan downward so the lowest index is left standing
    always_comb begin
        s_found = 1'b0;
        s_index = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                s_found = 1'b1;
                s_index = i[TLB_IDX_W-1:0];
            end
        end
    end

    // Fields read as zero on a miss
    assign s_ppn = s_found ? ppn_q[s_index] : '0;
    assign s_ps  = s_found ? ps_q[s_index]  : '0;
    assign s_plv = s_found ? plv_q[s_index] : '0;
    assign s_mat = s_found ? mat_q[s_index] : '0;
    assign s_d   = s_found & d_q[s_index];
    assign s_v   = s_found & v_q[s_index];

endmodule

/* logic/mmu_translate.sv */
`timescale 1ns/10ps

module mmu_translate (
    input  logic [31:0]                      va,
    input  logic [1:0]                       flag,
    input  logic                             crmd_da,
    input  logic                             crmd_pg,
    input  logic [1:0]                       crmd_plv,
    input  logic [31:0]                      dmw0,
    input  logic [31:0]                      dmw1,
    input  logic                             s_found,
    input  logic [mmu_pkg::PPN_W-1:0]        s_ppn,
    input  logic [5:0]                       s_ps,
    input  logic [1:0]                       s_plv,
    input  logic                             s_d,
    input  logic                             s_v,
    output logic [mmu_pkg::VPPN_W-1:0]       s_vppn,
    output logic [31:0]                      pa_next,
    output logic [mmu_pkg::EXC_W-1:0]        exc_next,
    output logic                             dmw_hit_next
);
    import mmu_pkg::*;

    logic        direct;                                    // DA mode
    logic        dmw_hit0;
    logic        dmw_hit1;
    logic        tlb_trans;                                 // Page path taken
    logic        is_inst;
    logic [31:0] dmw_pa0;
    logic [31:0] dmw_pa1;
    logic [31:0] tlb_pa;

    assign direct  = crmd_da & ~crmd_pg;
    assign is_inst = (flag == FLAG_INST);

    // Window hits when its bit for the current PLV is set and vseg matches
    assign dmw_hit0 = dmw0[crmd_plv] && (dmw0[DMW_VSEG_HI:DMW_VSEG_LO] == va[31:29]);
    assign dmw_hit1 = dmw1[crmd_plv] && (dmw1[DMW_VSEG_HI:DMW_VSEG_LO] == va[31:29]);

    assign dmw_pa0 = {dmw0[DMW_PSEG_HI:DMW_PSEG_LO], va[28:0]};
    assign dmw_pa1 = {dmw1[DMW_PSEG_HI:DMW_PSEG_LO], va[28:0]};

    assign tlb_trans = ~direct & ~dmw_hit0 & ~dmw_hit1;

    assign s_vppn = va[31:13];                              // Search key

    // 4 KB keeps 12 offset bits, 4 MB keeps 22
    assign tlb_pa = (s_ps == PS_4K) ? {s_ppn, va[11:0]}
                                    : {s_ppn[PPN_W-1:10], va[21:0]};

    // Direct first, then window 0, window 1, page
    always_comb begin
        if (direct) begin
            pa_next = va;
        end else if (dmw_hit0) begin
            pa_next = dmw_pa0;
        end else if (dmw_hit1) begin
            pa_next = dmw_pa1;
        end else begin
            pa_next = tlb_pa;
        end
    end

    // Raw flag vector, no priority between flags
    always_comb begin
        exc_next           = '0;
        exc_next[EXC_TLBR] = tlb_trans & ~s_found;
        exc_next[EXC_PIF]  = tlb_trans & ~s_v;
        exc_next[EXC_PPI]  = tlb_trans & (crmd_plv > s_plv);
        exc_next[EXC_PIL]  = ~is_inst & tlb_trans & ~s_v;   // Fetch never flags load
        exc_next[EXC_PIS]  = ~is_inst & tlb_trans & ~s_v;
        exc_next[EXC_PME]  = ~is_inst & tlb_trans & ~s_d;
    end

    assign dmw_hit_next = dmw_hit0 | dmw_hit1;              // Reported in any mode

endmodule

/* logic/mmu_result_reg.sv */
`timescale 1ns/10ps

module mmu_result_reg (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             req,
    input  logic [31:0]                      pa_next,
    input  logic [mmu_pkg::EXC_W-1:0]        exc_next,
    input  logic                             dmw_hit_next,
    input  logic [1:0]                       crmd_plv,
    output logic                             rsp_valid,
    output logic [31:0]                      pa,
    output logic [mmu_pkg::EXC_W-1:0]        exc_ecode,
    output logic                             dmw_hit,
    output logic [1:0]                       plv
);

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            pa        <= '0;
            exc_ecode <= '0;
            dmw_hit   <= 1'b0;
            plv       <= '0;
        end else begin
            rsp_valid <= req;                               // One pulse per request
            if (req) begin
                pa        <= pa_next;
                exc_ecode <= exc_next;
                dmw_hit   <= dmw_hit_next;
                plv       <= crmd_plv;                      // PLV at request time
            end
        end
    end

endmodule

/* logic/mmu_top.sv */
`timescale 1ns/10ps

module mmu_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             csr_we,
    input  logic [mmu_pkg::CSR_NUM_W-1:0]    csr_num,
    input  mmu_pkg::csr_word_u               csr_wdata,
    input  logic                             tlb_we,
    input  logic [mmu_pkg::TLB_IDX_W-1:0]    tlb_widx,
    input  logic                             tlb_e,
    input  logic [mmu_pkg::VPPN_W-1:0]       tlb_vppn,
    input  logic [5:0]                       tlb_ps,
    input  logic                             tlb_g,
    input  logic [mmu_pkg::ASID_W-1:0]       tlb_asid,
    input  logic [mmu_pkg::PPN_W-1:0]        tlb_ppn,
    input  logic [1:0]                       tlb_plv,
    input  logic [1:0]                       tlb_mat,
    input  logic                             tlb_d,
    input  logic                             tlb_v,
    input  logic                             req,
    input  logic [31:0]                      va,
    input  logic [1:0]                       flag,
    output logic                             rsp_valid,
    output logic [31:0]                      pa,
    output logic [mmu_pkg::EXC_W-1:0]        exc_ecode,
    output logic                             dmw_hit,
    output logic [1:0]                       plv
);
    import mmu_pkg::*;

    logic              crmd_da;                             // Decoded CRMD
    logic              crmd_pg;
    logic [1:0]        crmd_plv;
    logic [ASID_W-1:0] asid;
    logic [31:0]       dmw0;
    logic [31:0]       dmw1;

    logic [VPPN_W-1:0] s_vppn;                              // TLB search port
    logic              s_found;
    logic [PPN_W-1:0]  s_ppn;
    logic [5:0]        s_ps;
    logic [1:0]        s_plv;
    logic              s_d;
    logic              s_v;

    logic [31:0]       pa_next;                             // Translator to register
    logic [EXC_W-1:0]  exc_next;
    logic              dmw_hit_next;

    mmu_csr_file u_csr (
        .clk(clk), .rst(rst), .csr_we(csr_we), .csr_num(csr_num), .csr_wdata(csr_wdata),
        .crmd_da(crmd_da), .crmd_pg(crmd_pg), .crmd_plv(crmd_plv),
        .asid(asid), .dmw0(dmw0), .dmw1(dmw1)
    );

    // Index and MAT are not used by the translator
    mmu_tlb u_tlb (
        .clk(clk), .rst(rst), .tlb_we(tlb_we), .tlb_widx(tlb_widx),
        .tlb_e(tlb_e), .tlb_vppn(tlb_vppn), .tlb_ps(tlb_ps), .tlb_g(tlb_g),
        .tlb_asid(tlb_asid), .tlb_ppn(tlb_ppn), .tlb_plv(tlb_plv), .tlb_mat(tlb_mat),
        .tlb_d(tlb_d), .tlb_v(tlb_v),
        .s_vppn(s_vppn), .s_asid(asid),
        .s_found(s_found), .s_index(), .s_ppn(s_ppn), .s_ps(s_ps),
        .s_plv(s_plv), .s_mat(), .s_d(s_d), .s_v(s_v)
    );

    mmu_translate u_xlate (
        .va(va), .flag(flag), .crmd_da(crmd_da), .crmd_pg(crmd_pg), .crmd_plv(crmd_plv),
        .dmw0(dmw0), .dmw1(dmw1),
        .s_found(s_found), .s_ppn(s_ppn), .s_ps(s_ps), .s_plv(s_plv), .s_d(s_d), .s_v(s_v),
        .s_vppn(s_vppn), .pa_next(pa_next), .exc_next(exc_next), .dmw_hit_next(dmw_hit_next)
    );

    mmu_result_reg u_rsp (
        .clk(clk), .rst(rst), .req(req),
        .pa_next(pa_next), .exc_next(exc_next), .dmw_hit_next(dmw_hit_next),
        .crmd_plv(crmd_plv),
        .rsp_valid(rsp_valid), .pa(pa), .exc_ecode(exc_ecode), .dmw_hit(dmw_hit), .plv(plv)
    );

endmodule

/* tests/mmu_checker.sv */
`timescale 1ns/10ps

module mmu_checker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rsp_valid,      // DUT result side
    input  logic [31:0]                      pa,
    input  logic [mmu_pkg::EXC_W-1:0]        exc_ecode,
    input  logic                             dmw_hit,
    input  logic [1:0]                       plv,
    input  logic                             exp_stb,        // Expected values, one per request
    input  logic [15:0]                      exp_id,
    input  logic [31:0]                      exp_pa,
    input  logic                             exp_pa_chk,
    input  logic [mmu_pkg::EXC_W-1:0]        exp_exc,
    input  logic                             exp_dmw,
    input  logic [1:0]                       exp_plv,
    output int                               n_checked,
    output int                               n_failed,
    output int                               n_errors
);
    import mmu_pkg::*;

    logic             due;                                  // Result expected this cycle
    logic [15:0]      q_id;
    logic [31:0]      q_pa;
    logic             q_pa_chk;
    logic [EXC_W-1:0] q_exc;
    logic             q_dmw;
    logic [1:0]       q_plv;
    int               bad;

    // Latch expectations on the same edge the DUT takes req
    always @(posedge clk) begin
        if (rst) begin
            due <= 1'b0;
        end else begin
            due <= exp_stb;
            if (exp_stb) begin
                q_id     <= exp_id;
                q_pa     <= exp_pa;
                q_pa_chk <= exp_pa_chk;
                q_exc    <= exp_exc;
                q_dmw    <= exp_dmw;
                q_plv    <= exp_plv;
            end
        end
    end

    // Compare at the falling edge, registered outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            n_checked = 0;
            n_failed  = 0;
            n_errors  = 0;
        end else if (due) begin
            bad = 0;
            if (!rsp_valid) begin
                $display("test %0d: rsp_valid did not rise one cycle after the request", q_id);
                bad++;
            end else begin
                if (q_pa_chk && (pa !== q_pa)) begin
                    $display("ERROR pa: got 0x%08h, expected 0x%08h (test %0d)", pa, q_pa, q_id);
                    bad++;
                end
                if (exc_ecode !== q_exc) begin
                    $display("ERROR exc_ecode: got 0x%02h, expected 0x%02h (test %0d)",
                             exc_ecode, q_exc, q_id);
                    bad++;
                end
                if (dmw_hit !== q_dmw) begin
                    $display("ERROR dmw_hit: got 0x%h, expected 0x%h (test %0d)",
                             dmw_hit, q_dmw, q_id);
                    bad++;
                end
                if (plv !== q_plv) begin
                    $display("ERROR plv: got 0x%h, expected 0x%h (test %0d)", plv, q_plv, q_id);
                    bad++;
                end
            end
            n_checked++;
            n_errors += bad;
            if (bad != 0) begin
                n_failed++;
                $display("test %0d: FAIL", q_id);
            end else begin
                $display("test %0d: pass", q_id);
            end
        end else if (rsp_valid) begin
            $display("rsp_valid was high in a cycle with no request before it");
            n_errors++;
        end
    end

endmodule

/* tests/mmu_tb.sv */
`timescale 1ns/10ps

module mmu_tb;
    import mmu_pkg::*;

    typedef enum logic [1:0] {ROW_CSR, ROW_TLB, ROW_REQ} row_kind_e;

    typedef struct packed {
        row_kind_e           kind;
        logic [CSR_NUM_W-1:0] num;
        logic [31:0]         wdata;
        logic [TLB_IDX_W-1:0] idx;
        logic [VPPN_W-1:0]   vppn;
        logic [5:0]          ps;
        logic                g;
        logic [ASID_W-1:0]   asid;
        logic [PPN_W-1:0]    ppn;
        logic [1:0]          eplv;
        logic                d;
        logic                v;
        logic [31:0]         va;
        logic [1:0]          flag;
        logic [15:0]         id;
        logic [31:0]         exp_pa;
        logic                pa_chk;                        // Page miss leaves pa undefined
        logic [EXC_W-1:0]    exp_exc;
        logic                exp_dmw;
        logic [1:0]          exp_plv;
    } row_t;

    logic clk;
    logic rst;
    logic csr_we;
    logic [CSR_NUM_W-1:0] csr_num;
    csr_word_u csr_wdata;
    logic tlb_we;
    logic [TLB_IDX_W-1:0] tlb_widx;
    logic tlb_e;
    logic tlb_g;
    logic tlb_d;
    logic tlb_v;
    logic [VPPN_W-1:0] tlb_vppn;
    logic [5:0] tlb_ps;
    logic [ASID_W-1:0] tlb_asid;
    logic [PPN_W-1:0] tlb_ppn;
    logic [1:0] tlb_plv;
    logic [1:0] tlb_mat;
    logic req;
    logic [31:0] va;
    logic [1:0] flag;
    logic rsp_valid;
    logic dmw_hit;
    logic [31:0] pa;
    logic [EXC_W-1:0] exc_ecode;
    logic [1:0] plv;

    logic exp_stb;                                          // To the checker
    logic exp_pa_chk;
    logic exp_dmw;
    logic [15:0] exp_id;
    logic [31:0] exp_pa;
    logic [EXC_W-1:0] exp_exc;
    logic [1:0] exp_plv;
    int n_checked;
    int n_failed;
    int n_errors;

    row_t   rows[$];
    row_t   cur;
    int     n_reqs;
    logic [1:0] cur_plv;                                    // CRMD plv seen by later rows
    logic   table_ready;
    integer seed;
    logic [31:0] rnd;
    logic [31:0] rva;

    mmu_top dut0 (
        .clk(clk), .rst(rst), .csr_we(csr_we), .csr_num(csr_num), .csr_wdata(csr_wdata),
        .tlb_we(tlb_we), .tlb_widx(tlb_widx), .tlb_e(tlb_e), .tlb_vppn(tlb_vppn),
        .tlb_ps(tlb_ps), .tlb_g(tlb_g), .tlb_asid(tlb_asid), .tlb_ppn(tlb_ppn),
        .tlb_plv(tlb_plv), .tlb_mat(tlb_mat), .tlb_d(tlb_d), .tlb_v(tlb_v),
        .req(req), .va(va), .flag(flag),
        .rsp_valid(rsp_valid), .pa(pa), .exc_ecode(exc_ecode), .dmw_hit(dmw_hit), .plv(plv)
    );

    mmu_checker chk0 (
        .clk(clk), .rst(rst), .rsp_valid(rsp_valid), .pa(pa), .exc_ecode(exc_ecode),
        .dmw_hit(dmw_hit), .plv(plv), .exp_stb(exp_stb), .exp_id(exp_id), .exp_pa(exp_pa),
        .exp_pa_chk(exp_pa_chk), .exp_exc(exp_exc), .exp_dmw(exp_dmw), .exp_plv(exp_plv),
        .n_checked(n_checked), .n_failed(n_failed), .n_errors(n_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                             // 20 ns period
    end

    function automatic csr_word_u crmd_word(input logic pg, input logic da,
                                            input logic [1:0] lvl);
        csr_word_u w;
        w = '0;
        w.crmd.pg  = pg;
        w.crmd.da  = da;
        w.crmd.plv = lvl;
        return w;
    endfunction

    function automatic csr_word_u asid_word(input logic [ASID_W-1:0] id);
        csr_word_u w;
        w = '0;
        w.asid.asid = id;
        return w;
    endfunction

    function automatic csr_word_u dmw_word(input logic [2:0] vseg, input logic [2:0] pseg,
                                           input logic plv0, input logic plv3);
        csr_word_u w;
        w = '0;
        w.dmw.vseg = vseg;
        w.dmw.pseg = pseg;
        w.dmw.plv0 = plv0;
        w.dmw.plv3 = plv3;
        return w;
    endfunction

    task automatic csr_write_row(input logic [CSR_NUM_W-1:0] num, input csr_word_u w);
        row_t r;
        r = '0;
        r.kind  = ROW_CSR;
        r.num   = num;
        r.wdata = w;
        if (num == CSR_CRMD)
            cur_plv = w.crmd.plv;                           // Track privilege for expectations
        rows.push_back(r);
    endtask

    task automatic tlb_write_row(input logic [3:0] idx, input logic [VPPN_W-1:0] vppn,
                                 input logic [5:0] ps, input logic g,
                                 input logic [ASID_W-1:0] id,
                                 input logic [PPN_W-1:0] ppn, input logic [1:0] lvl,
                                 input logic d, input logic v);
        row_t r;
        r = '0;
        r.kind = ROW_TLB;
        r.idx  = idx;
        r.vppn = vppn;
        r.ps   = ps;
        r.g    = g;
        r.asid = id;
        r.ppn  = ppn;
        r.eplv = lvl;
        r.d    = d;
        r.v    = v;
        rows.push_back(r);
    endtask

    task automatic request_row(input logic [31:0] a, input logic [1:0] f,
                               input logic [31:0] epa, input logic chk,
                               input logic [EXC_W-1:0] eexc, input logic edmw);
        row_t r;
        r = '0;
        r.kind    = ROW_REQ;
        r.va      = a;
        r.flag    = f;
        r.id      = n_reqs[15:0];
        r.exp_pa  = epa;
        r.pa_chk  = chk;
        r.exp_exc = eexc;
        r.exp_dmw = edmw;
        r.exp_plv = cur_plv;
        n_reqs++;
        rows.push_back(r);
    endtask

    initial begin
        seed = 32'h88e4;
        n_reqs = 0;
        cur_plv = 2'd0;                                     // CRMD after reset
        table_ready = 1'b0;

        // Back to back requests in direct mode after reset
        request_row(32'h1234_5678, FLAG_DATA, 32'h1234_5678, 1, 6'h00, 0);
        request_row(32'hdead_beef, FLAG_INST, 32'hdead_beef, 1, 6'h00, 0);
        rnd = $random(seed);
        request_row(rnd, FLAG_DATA, rnd, 1, 6'h00, 0);
        rnd = $random(seed);
        request_row(rnd, FLAG_INST, rnd, 1, 6'h00, 0);

        // DMW0 maps seg 5 to 1 at PLV0 and DMW1 maps seg 4 to 0 at PLV0 and PLV3
        csr_write_row(CSR_DMW0, dmw_word(3'd5, 3'd1, 1'b1, 1'b0));
        csr_write_row(CSR_DMW1, dmw_word(3'd4, 3'd0, 1'b1, 1'b1));
        request_row(32'ha000_1000, FLAG_DATA, 32'ha000_1000, 1, 6'h00, 1);  // Hit seen in DA
        csr_write_row(CSR_CRMD, crmd_word(1'b1, 1'b0, 2'd0));
        request_row(32'ha123_4567, FLAG_DATA, 32'h2123_4567, 1, 6'h00, 1);
        request_row(32'h8765_4321, FLAG_INST, 32'h0765_4321, 1, 6'h00, 1);
        rnd = $random(seed);
        rva = {3'b101, rnd[28:0]};
        request_row(rva, FLAG_DATA, {3'b001, rva[28:0]}, 1, 6'h00, 1);
        rnd = $random(seed);
        rva = {3'b100, rnd[28:0]};
        request_row(rva, FLAG_INST, {3'b000, rva[28:0]}, 1, 6'h00, 1);
        csr_write_row(CSR_DMW1, dmw_word(3'd5, 3'd3, 1'b1, 1'b1));
        request_row(32'hbfff_fffc, FLAG_DATA, 32'h3fff_fffc, 1, 6'h00, 1);  // Window 0 wins
        csr_write_row(CSR_CRMD, crmd_word(1'b1, 1'b0, 2'd3));
        request_row(32'hbfff_fffc, FLAG_DATA, 32'h7fff_fffc, 1, 6'h00, 1);  // DMW0 off at PLV3
        request_row(32'h8000_0000, FLAG_DATA, 32'h0, 0, 6'h3f, 0);          // Miss sets all six

        // 4 KB and 4 MB pages at PLV0
        csr_write_row(CSR_CRMD, crmd_word(1'b1, 1'b0, 2'd0));
        tlb_write_row(4'd2, 19'h00201, PS_4K, 1'b0, 10'h000, 20'h12345, 2'd0, 1'b1, 1'b1);
        request_row(32'h0040_2abc, FLAG_DATA, 32'h1234_5abc, 1, 6'h00, 0);
        request_row(32'h0040_3abc, FLAG_DATA, 32'h1234_5abc, 1, 6'h00, 0);  // va[12] ignored
        rnd = $random(seed);
        rva = {19'h00201, rnd[12:0]};
        request_row(rva, FLAG_INST, {20'h12345, rva[11:0]}, 1, 6'h00, 0);
        tlb_write_row(4'd5, 19'h06000, PS_4M, 1'b0, 10'h000, 20'habc00, 2'd0, 1'b1, 1'b1);
        request_row(32'h0c12_3456, FLAG_DATA, 32'habd2_3456, 1, 6'h00, 0);
        request_row(32'h0c52_3456, FLAG_INST, 32'habd2_3456, 1, 6'h00, 0);  // va[22] ignored
        rnd = $random(seed);
        rva = {9'h018, rnd[22:0]};
        request_row(rva, FLAG_DATA, {10'h2af, rva[21:0]}, 1, 6'h00, 0);
        tlb_write_row(4'd1, 19'h00201, PS_4K, 1'b0, 10'h000, 20'h55555, 2'd0, 1'b1, 1'b1);
        request_row(32'h0040_2abc, FLAG_DATA, 32'h5555_5abc, 1, 6'h00, 0);  // Lower index wins

        // Global entry keeps hitting after an ASID change
        tlb_write_row(4'd7, 19'h00300, PS_4K, 1'b1, 10'h3ff, 20'h00777, 2'd0, 1'b1, 1'b1);
        request_row(32'h0060_0123, FLAG_DATA, 32'h0077_7123, 1, 6'h00, 0);
        csr_write_row(CSR_ASID, asid_word(10'h005));
        request_row(32'h0040_2abc, FLAG_DATA, 32'h0, 0, 6'h3d, 0);          // pil pis pif pme tlbr
        request_row(32'h0c12_3456, FLAG_INST, 32'h0, 0, 6'h09, 0);          // pif tlbr
        request_row(32'h0060_0123, FLAG_DATA, 32'h0077_7123, 1, 6'h00, 0);

        // Invalid and clean PLV0 page used from PLV3
        tlb_write_row(4'd9, 19'h00400, PS_4K, 1'b1, 10'h000, 20'h0abcd, 2'd0, 1'b0, 1'b0);
        csr_write_row(CSR_CRMD, crmd_word(1'b1, 1'b0, 2'd3));
        request_row(32'h0080_0fed, FLAG_DATA, 32'h0abc_dfed, 1, 6'h3e, 0);  // All but tlbr
        request_row(32'h0080_0fed, FLAG_INST, 32'h0abc_dfed, 1, 6'h0a, 0);  // pif ppi
        request_row(32'h0060_0123, FLAG_DATA, 32'h0077_7123, 1, 6'h02, 0);  // ppi only

        // Unknown CSR numbers change nothing
        csr_write_row(14'h001, crmd_word(1'b0, 1'b1, 2'd0));
        csr_write_row(14'h182, dmw_word(3'd0, 3'd7, 1'b1, 1'b1));
        request_row(32'h0080_0fed, FLAG_DATA, 32'h0abc_dfed, 1, 6'h3e, 0);
        request_row(32'hbfff_fffc, FLAG_DATA, 32'h7fff_fffc, 1, 6'h00, 1);
        table_ready = 1'b1;

        rst = 1'b1;
        csr_we = 1'b0;
        csr_num = '0;
        csr_wdata = '0;
        tlb_we = 1'b0;
        tlb_widx = '0;
        tlb_e = 1'b0;
        tlb_vppn = '0;
        tlb_ps = '0;
        tlb_g = 1'b0;
        tlb_asid = '0;
        tlb_ppn = '0;
        tlb_plv = '0;
        tlb_mat = '0;
        tlb_d = 1'b0;
        tlb_v = 1'b0;
        req = 1'b0;
        va = '0;
        flag = '0;
        exp_stb = 1'b0;
        exp_id = '0;
        exp_pa = '0;
        exp_pa_chk = 1'b0;
        exp_exc = '0;
        exp_dmw = 1'b0;
        exp_plv = '0;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // One row per cycle
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            cur = rows[i];
            csr_we     <= (cur.kind == ROW_CSR);
            csr_num    <= cur.num;
            csr_wdata  <= cur.wdata;
            tlb_we     <= (cur.kind == ROW_TLB);
            tlb_widx   <= cur.idx;
            tlb_e      <= 1'b1;
            tlb_vppn   <= cur.vppn;
            tlb_ps     <= cur.ps;
            tlb_g      <= cur.g;
            tlb_asid   <= cur.asid;
            tlb_ppn    <= cur.ppn;
            tlb_plv    <= cur.eplv;
            tlb_mat    <= 2'd1;                             // Stored only
            tlb_d      <= cur.d;
            tlb_v      <= cur.v;
            req        <= (cur.kind == ROW_REQ);
            va         <= cur.va;
            flag       <= cur.flag;
            exp_stb    <= (cur.kind == ROW_REQ);
            exp_id     <= cur.id;
            exp_pa     <= cur.exp_pa;
            exp_pa_chk <= cur.pa_chk;
            exp_exc    <= cur.exp_exc;
            exp_dmw    <= cur.exp_dmw;
            exp_plv    <= cur.exp_plv;
        end
        @(posedge clk);
        csr_we  <= 1'b0;
        tlb_we  <= 1'b0;
        req     <= 1'b0;
        exp_stb <= 1'b0;

        wait (n_checked == n_reqs);
        repeat (2) @(negedge clk);                          // Catch a stray rsp_valid
        $display("Tests checked %0d, failed %0d, value errors %0d",
                 n_checked, n_failed, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Four cycles per row plus margin for reset and drain
    initial begin
        wait (table_ready);
        repeat (rows.size() * 4 + 50) @(posedge clk);
        $display("Watchdog expired before every request was answered and checked");
        $display("Done: errors found");
        $finish;
    end

endmodule

/* tb.f */
logic/mmu_pkg.sv
logic/mmu_csr_file.sv
logic/mmu_tlb.sv
logic/mmu_translate.sv
logic/mmu_result_reg.sv
logic/mmu_top.sv
tests/mmu_checker.sv
tests/mmu_tb.sv

/* Bender.yml */
package:
  name: mmu

sources:
  - logic/mmu_pkg.sv
  - logic/mmu_csr_file.sv
  - logic/mmu_tlb.sv
  - logic/mmu_translate.sv
  - logic/mmu_result_reg.sv
  - logic/mmu_top.sv
  - target: test
    files:
      - tests/mmu_checker.sv
      - tests/mmu_tb.sv
